// File: dv/dbg_clock_gen.sv
`timescale 1ns/1ps

module dbg_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;   // 4 ns period
    end

    initial begin
        o_reset = 1'b1;
        repeat (8) @(posedge o_clk);
        #1 o_reset = 1'b0;           // released just after the edge
    end

endmodule

// File: dv/debug_subsystem_sva.sv
`timescale 1ns/1ps

module debug_subsystem_sva (
    input logic i_clk,
    input logic i_reset,
    input logic i_halt,
    input logic i_pipe_reset,
    input logic i_stall,
    input logic i_fifo_push,
    input logic i_fifo_full
);

    int unsigned fail_count = 0;   // read by the testbench at the end

    a_pipe_reset_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pipe_reset |=> !i_pipe_reset)
        else begin fail_count++; $error("pipe reset lasted more than one cycle"); end

    a_fifo_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fifo_full |-> !i_fifo_push)
        else begin fail_count++; $error("push into a full transmit FIFO"); end

    // pipeline must come out of reset halted
    a_halt_after_reset: assert property (@(posedge i_clk)
        i_reset |=> i_halt)
        else begin fail_count++; $error("halt low right after reset"); end

    a_stall_only_running: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |-> !i_halt)
        else begin fail_count++; $error("stall high while the pipeline is halted"); end

endmodule

// File: dv/debug_subsystem_tb.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module debug_subsystem_tb;

    localparam int TIMEOUT = 2000;   // cycles allowed per wait

    logic clk, reset;
    logic data_ready, program_end, tx_pop, tx_enable;
    logic [31:0] host_data, reg_data, mem_data, inst, tx_data;
    logic [8:0] inst_addr;
    logic halt, pipe_reset, stall, tx_empty;
    logic [4:0] reg_addr;
    logic [7:0] mem_addr;
    dbg_pkg::pipe_snapshot_t snapshot;
    logic [351:0] snap_bits;         // snapshot with two zero pad bits on top
    logic [31:0] dmem [64];
    logic [31:0] rx_q[$];
    logic [31:0] exp_q[$];
    int run_count = 0;
    int end_after = 1000;
    int halt_low_count = 0;
    int stall_count = 0;
    int pipe_reset_count = 0;

    dbg_clock_gen u_clock_gen (.o_clk(clk), .o_reset(reset));

    debug_subsystem DUT (
        .i_clk(clk), .i_reset(reset), .i_data_ready(data_ready), .i_data(host_data),
        .i_program_end(program_end), .i_snapshot(snapshot), .i_reg_data(reg_data),
        .i_mem_data(mem_data), .i_inst_addr(inst_addr), .o_halt(halt),
        .o_pipe_reset(pipe_reset), .o_stall(stall), .o_reg_addr(reg_addr),
        .o_mem_addr(mem_addr), .o_inst(inst), .i_tx_pop(tx_pop), .o_tx_data(tx_data),
        .o_tx_empty(tx_empty)
    );

    bind debug_subsystem debug_subsystem_sva u_sva (
        .i_clk(i_clk), .i_reset(i_reset), .i_halt(o_halt), .i_pipe_reset(o_pipe_reset),
        .i_stall(o_stall), .i_fifo_push(fifo_push), .i_fifo_full(fifo_full)
    );

    function automatic logic [31:0] reg_value(input logic [4:0] addr);
        return 32'h5A00_0000 | (32'(addr) << 16) | (32'h0000_00FF - 32'(addr));
    endfunction

    assign reg_data = reg_value(reg_addr);     // register file model
    assign mem_data = dmem[mem_addr[7:2]];     // data memory model
    assign snapshot = snap_bits[349:0];

    // pipeline and transmitter observers, sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (!halt) begin
                run_count++;
                halt_low_count++;
            end
            if (stall) stall_count++;
            if (pipe_reset) begin
                pipe_reset_count++;
                run_count = 0;                 // program counter back to start
            end
            if (tx_pop && !tx_empty) rx_q.push_back(tx_data);
        end
    end

    always @(posedge clk) begin
        #1;
        program_end = (run_count >= end_after);
        tx_pop      = tx_enable && !tx_empty;
    end

    task automatic stop_with_failure;
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT: no %s within %0d cycles", what, TIMEOUT);
        stop_with_failure();
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_word(input logic [31:0] word);
        data_ready = 1'b1;
        host_data  = word;
        @(posedge clk);
        #1;
        data_ready = 1'b0;
    endtask

    task automatic fill_snapshot;
        for (int i = 0; i < `DBG_LATCH_WORDS; i++) snap_bits[i*32 +: 32] = $urandom();
        snap_bits[351:350] = 2'b00;
    endtask

    task automatic fill_data_memory;
        int idx [4];
        idx = '{0, 9, 33, 63};                   // first and last word included
        foreach (dmem[a]) dmem[a] = '0;
        foreach (idx[i]) dmem[idx[i]] = $urandom() | 32'h1;
    endtask

    // predicted dump order: registers, latches, data/address pairs, end marker
    task automatic expect_dump;
        exp_q.delete();
        rx_q.delete();
        for (int r = 0; r < `DBG_REG_COUNT; r++) exp_q.push_back(reg_value(5'(r)));
        for (int i = 0; i < `DBG_LATCH_WORDS; i++) exp_q.push_back(snap_bits[i*32 +: 32]);
        foreach (dmem[a]) begin
            if (dmem[a] != '0) begin
                exp_q.push_back(dmem[a]);
                exp_q.push_back(32'(a * 4));
            end
        end
        exp_q.push_back(`DBG_END_MARK);
    endtask

    task automatic collect_dump;
        int n;
        n = 0;
        while (rx_q.size() < exp_q.size()) begin
            if (n == TIMEOUT) report_timeout("complete dump");
            @(posedge clk);
            #1;
            n++;
        end
        wait_cycles(4);                          // any extra word would show up here
        check("dump length", rx_q.size(), exp_q.size());
        check("tx_empty after dump", tx_empty, 1'b1);
        foreach (exp_q[i]) check($sformatf("dump word %0d", i), rx_q[i], exp_q[i]);
    endtask

    task automatic wait_pipe_reset(input int target);
        int n;
        n = 0;
        while (pipe_reset_count < target) begin
            if (n == TIMEOUT) report_timeout("pipe reset pulse");
            @(posedge clk);
            #1;
            n++;
        end
        wait_cycles(2);
        check("pipe reset pulses", pipe_reset_count, target);
    endtask

    task automatic check_assertions;
        check("assertion failures", DUT.u_sva.fail_count, 0);
    endtask

    task automatic test_reset_levels;
        check("halt after reset", halt, 1'b1);
        check("pipe_reset after reset", pipe_reset, 1'b0);
        check("stall after reset", stall, 1'b0);
        check("tx_empty after reset", tx_empty, 1'b1);
    endtask

    task automatic test_commands_before_load;
        int h;
        h = halt_low_count;
        send_word(`DBG_CMD_CONT);
        wait_cycles(5);
        send_word(`DBG_CMD_STEP);
        wait_cycles(5);
        send_word(`DBG_CMD_NEXT);
        wait_cycles(5);
        check("halt low cycles without program", halt_low_count - h, 0);
        check("halt without program", halt, 1'b1);
        check("tx_empty without program", tx_empty, 1'b1);
    endtask

    task automatic test_loading;
        logic [31:0] prog [5];
        int p;
        prog = '{32'h0010_0093, 32'h0020_0113, 32'h0020_81B3, 32'h0000_0013, `DBG_END_INSTR};
        p = pipe_reset_count;
        send_word(`DBG_CMD_LOAD);
        foreach (prog[i]) begin
            send_word(prog[i]);
            wait_cycles(1);                      // loader writes in the following cycle
        end
        wait_pipe_reset(p + 1);
        foreach (prog[i]) begin
            inst_addr = 9'(i * 4);
            wait_cycles(1);
            check($sformatf("inst at 0x%0h", i * 4), inst, prog[i]);
        end
    endtask

    task automatic test_continuous;
        int p, s;
        end_after = 10;
        tx_enable = 1'b1;
        expect_dump();
        p = pipe_reset_count;
        s = stall_count;
        send_word(`DBG_CMD_CONT);
        check("halt after cont", halt, 1'b0);
        collect_dump();
        wait_pipe_reset(p + 1);
        check("stall cycles", stall_count - s, `DBG_DRAIN_CYCLES + 1);
        check("halt after run", halt, 1'b1);
    endtask

    task automatic test_stepping;
        int h, p;
        end_after = 100000;                      // steps never reach the end
        tx_enable = 1'b1;
        send_word(`DBG_CMD_STEP);
        wait_cycles(2);
        check("halt in step wait", halt, 1'b1);
        for (int k = 0; k < 2; k++) begin
            fill_snapshot();
            expect_dump();
            h = halt_low_count;
            send_word(`DBG_CMD_NEXT);
            collect_dump();
            check("halt low cycles per step", halt_low_count - h, 1);
        end
        p = pipe_reset_count;
        send_word(`DBG_CMD_CANCEL);
        wait_pipe_reset(p + 1);
        h = halt_low_count;
        send_word(`DBG_CMD_NEXT);
        wait_cycles(10);
        check("halt low cycles after cancel", halt_low_count - h, 0);
        check("tx_empty after cancel", tx_empty, 1'b1);
    endtask

    task automatic test_back_pressure;
        int p;
        int n;
        end_after = 10;
        tx_enable = 1'b0;
        fill_snapshot();
        expect_dump();
        p = pipe_reset_count;
        send_word(`DBG_CMD_CONT);
        n = 0;
        while (DUT.u_tx_fifo.o_full !== 1'b1) begin
            if (n == TIMEOUT) report_timeout("full transmit FIFO");
            @(posedge clk);
            #1;
            n++;
        end
        wait_cycles(20);                         // dump must stay paused while full
        check("fifo full while held", DUT.u_tx_fifo.o_full, 1'b1);
        check("dump paused", pipe_reset_count - p, 0);
        tx_enable = 1'b1;
        collect_dump();
        wait_pipe_reset(p + 1);
    endtask

    initial begin
        int n;
        void'($urandom(51496));                  // one seed for the whole run
        data_ready = 1'b0;
        host_data  = '0;
        program_end = 1'b0;
        inst_addr  = '0;
        tx_pop     = 1'b0;
        tx_enable  = 1'b0;
        fill_snapshot();
        fill_data_memory();
        n = 0;
        while (reset !== 1'b0) begin
            if (n == 100) report_timeout("reset release");
            @(posedge clk);
            n++;
        end
        #1;
        test_reset_levels();
        test_commands_before_load();
        test_loading();
        test_continuous();
        check_assertions();
        test_stepping();
        test_back_pressure();
        check_assertions();
        $display("test passed");
        $finish;
    end

endmodule

// File: logic/dbg_controller.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_controller (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_data_ready,
    input  logic [`DBG_WORD_W-1:0]  i_data,
    input  logic                    i_program_end,
    input  logic [`DBG_WORD_W-1:0]  i_reg_data,
    input  logic [`DBG_WORD_W-1:0]  i_mem_data,
    input  logic [`DBG_WORD_W-1:0]  i_latch_word,
    input  logic                    i_fifo_full,
    input  logic                    i_prog_ready,
    input  logic                    i_step_mode,
    input  logic [`DBG_IMEM_AW-1:0] i_load_addr,
    input  logic                    i_drain_done,
    output dbg_pkg::mode_evt_t      o_evt,
    output logic                    o_halt,
    output logic                    o_pipe_reset,
    output logic                    o_stall,
    output logic                    o_imem_we,
    output logic [`DBG_IMEM_AW-1:0] o_imem_addr,
    output logic [`DBG_WORD_W-1:0]  o_imem_wdata,
    output logic [4:0]              o_reg_addr,
    output logic [`DBG_DMEM_AW-1:0] o_mem_addr,
    output logic [3:0]              o_latch_idx,
    output logic                    o_fifo_push,
    output logic [`DBG_WORD_W-1:0]  o_fifo_wdata
);

    localparam logic [4:0] LAST_REG   = 5'(`DBG_REG_COUNT - 1);
    localparam logic [3:0] LAST_LATCH = 4'(`DBG_LATCH_WORDS - 1);
    localparam logic [`DBG_DMEM_AW-1:0] LAST_MEM = {{(`DBG_DMEM_AW-2){1'b1}}, 2'b00};

    dbg_pkg::dbg_state_e    state, state_next;
    dbg_pkg::dbg_cmd_e      cmd;
    logic [`DBG_WORD_W-1:0] load_word_q;
    logic                   pipe_reset_next;
    logic                   mem_word_valid;

    function automatic dbg_pkg::dbg_cmd_e decode_cmd(input logic [`DBG_WORD_W-1:0] word);
        dbg_pkg::dbg_cmd_e c;
        case (word)
            `DBG_CMD_LOAD:   c = dbg_pkg::CMD_LOAD;
            `DBG_CMD_CONT:   c = dbg_pkg::CMD_CONT;
            `DBG_CMD_STEP:   c = dbg_pkg::CMD_STEP;
            `DBG_CMD_NEXT:   c = dbg_pkg::CMD_NEXT;
            `DBG_CMD_CANCEL: c = dbg_pkg::CMD_CANCEL;
            default:         c = dbg_pkg::CMD_NONE;
        endcase
        return c;
    endfunction

    assign cmd            = decode_cmd(i_data);
    assign mem_word_valid = (i_mem_data != '0) && !$isunknown(i_mem_data); // skip empty words

    // pipeline only advances in these two states
    assign o_halt  = !(state == dbg_pkg::ST_RUN || state == dbg_pkg::ST_STEP_EXEC);
    assign o_stall = (state == dbg_pkg::ST_RUN) && i_program_end;

    assign o_imem_we    = (state == dbg_pkg::ST_LOAD_WRITE);
    assign o_imem_addr  = i_load_addr;
    assign o_imem_wdata = load_word_q;

    always_comb begin
        state_next      = state;
        o_evt           = '0;
        o_fifo_push     = 1'b0;
        o_fifo_wdata    = i_reg_data;
        pipe_reset_next = 1'b0;
        case (state)
            dbg_pkg::ST_IDLE: begin
                if (i_data_ready) begin
                    if (cmd == dbg_pkg::CMD_LOAD) begin
                        o_evt.load_start = 1'b1;
                        state_next       = dbg_pkg::ST_LOAD_WAIT;
                    end else if (cmd == dbg_pkg::CMD_CONT && i_prog_ready) begin
                        o_evt.run_start = 1'b1;
                        state_next      = dbg_pkg::ST_RUN;
                    end else if (cmd == dbg_pkg::CMD_STEP && i_prog_ready) begin
                        o_evt.step_start = 1'b1;
                        state_next       = dbg_pkg::ST_STEP_WAIT;
                    end
                end
            end
            dbg_pkg::ST_LOAD_WAIT: begin
                if (i_data_ready) state_next = dbg_pkg::ST_LOAD_WRITE; // any word is program data
            end
            dbg_pkg::ST_LOAD_WRITE: begin
                if (load_word_q == `DBG_END_INSTR) begin
                    o_evt.load_done = 1'b1;
                    pipe_reset_next = 1'b1;
                    state_next      = dbg_pkg::ST_IDLE;
                end else begin
                    o_evt.load_word = 1'b1;
                    state_next      = dbg_pkg::ST_LOAD_WAIT;
                end
            end
            dbg_pkg::ST_RUN: begin
                o_evt.drain_tick = i_program_end;
                if (i_drain_done) state_next = dbg_pkg::ST_REG_ADDR;
            end
            dbg_pkg::ST_STEP_WAIT: begin
                if (i_data_ready && cmd == dbg_pkg::CMD_NEXT) begin
                    state_next = dbg_pkg::ST_STEP_EXEC;
                end else if (i_data_ready && cmd == dbg_pkg::CMD_CANCEL) begin
                    o_evt.session_end = 1'b1;
                    pipe_reset_next   = 1'b1;
                    state_next        = dbg_pkg::ST_IDLE;
                end
            end
            dbg_pkg::ST_STEP_EXEC: state_next = dbg_pkg::ST_REG_ADDR; // single clock of execution
            dbg_pkg::ST_REG_ADDR:  state_next = dbg_pkg::ST_REG_PUSH;
            dbg_pkg::ST_REG_PUSH: begin
                o_fifo_push = !i_fifo_full;
                if (!i_fifo_full) begin
                    state_next = (o_reg_addr == LAST_REG) ? dbg_pkg::ST_LATCH_PUSH
                                                          : dbg_pkg::ST_REG_ADDR;
                end
            end
            dbg_pkg::ST_LATCH_PUSH: begin
                o_fifo_push  = !i_fifo_full;
                o_fifo_wdata = i_latch_word;
                if (!i_fifo_full && o_latch_idx == LAST_LATCH) state_next = dbg_pkg::ST_MEM_ADDR;
            end
            dbg_pkg::ST_MEM_ADDR: state_next = dbg_pkg::ST_MEM_CHECK;
            dbg_pkg::ST_MEM_CHECK: begin
                o_fifo_wdata = i_mem_data;
                if (mem_word_valid) begin
                    o_fifo_push = !i_fifo_full;
                    if (!i_fifo_full) state_next = dbg_pkg::ST_MEM_PUSH_ADDR;
                end else begin
                    state_next = (o_mem_addr == LAST_MEM) ? dbg_pkg::ST_END_PUSH
                                                          : dbg_pkg::ST_MEM_ADDR;
                end
            end
            dbg_pkg::ST_MEM_PUSH_ADDR: begin
                o_fifo_push  = !i_fifo_full;
                o_fifo_wdata = {{(`DBG_WORD_W-`DBG_DMEM_AW){1'b0}}, o_mem_addr};
                if (!i_fifo_full) begin
                    state_next = (o_mem_addr == LAST_MEM) ? dbg_pkg::ST_END_PUSH
                                                          : dbg_pkg::ST_MEM_ADDR;
                end
            end
            dbg_pkg::ST_END_PUSH: begin
                o_fifo_push  = !i_fifo_full;
                o_fifo_wdata = `DBG_END_MARK;
                if (!i_fifo_full) begin
                    state_next = i_step_mode ? dbg_pkg::ST_STEP_WAIT : dbg_pkg::ST_RELEASE;
                end
            end
            dbg_pkg::ST_RELEASE: begin
                o_evt.session_end = 1'b1;
                pipe_reset_next   = 1'b1;
                state_next        = dbg_pkg::ST_IDLE;
            end
            default: state_next = dbg_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= dbg_pkg::ST_IDLE;
            o_pipe_reset <= 1'b0;
            o_reg_addr   <= '0;
            o_latch_idx  <= '0;
            o_mem_addr   <= '0;
        end else begin
            state        <= state_next;
            o_pipe_reset <= pipe_reset_next; // one cycle pulse
            // indices wrap back to zero at the end of each section
            if (state == dbg_pkg::ST_REG_PUSH && !i_fifo_full) o_reg_addr <= o_reg_addr + 1'b1;
            if (state == dbg_pkg::ST_LATCH_PUSH && !i_fifo_full) begin
                o_latch_idx <= (o_latch_idx == LAST_LATCH) ? '0 : o_latch_idx + 1'b1;
            end
            if ((state == dbg_pkg::ST_MEM_CHECK && !mem_word_valid) ||
                (state == dbg_pkg::ST_MEM_PUSH_ADDR && !i_fifo_full)) begin
                o_mem_addr <= o_mem_addr + 3'd4;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == dbg_pkg::ST_LOAD_WAIT && i_data_ready) load_word_q <= i_data;
    end

endmodule

// File: logic/dbg_inst_mem.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_inst_mem (
    input  logic                    i_clk,
    input  logic                    i_we,
    input  logic [`DBG_IMEM_AW-1:0] i_waddr,
    input  logic [`DBG_WORD_W-1:0]  i_wdata,
    input  logic [`DBG_IMEM_AW-1:0] i_raddr,
    output logic [`DBG_WORD_W-1:0]  o_rdata
);

    localparam int WORDS = 2 ** (`DBG_IMEM_AW - 2);

    logic [`DBG_WORD_W-1:0] mem [WORDS];

    // word aligned, the two low address bits are dropped
    always_ff @(posedge i_clk) begin
        if (i_we) mem[i_waddr[`DBG_IMEM_AW-1:2]] <= i_wdata;    // loader port
        o_rdata <= mem[i_raddr[`DBG_IMEM_AW-1:2]];              // fetch port, one cycle
    end

endmodule

// File: logic/dbg_latch_pack.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_latch_pack (
    input  dbg_pkg::pipe_snapshot_t i_snapshot,
    input  logic [3:0]              i_idx,
    output logic [`DBG_WORD_W-1:0]  o_word
);

    localparam int PACK_W = `DBG_LATCH_WORDS * `DBG_WORD_W;   // 352
    localparam int SNAP_W = $bits(dbg_pkg::pipe_snapshot_t); // 350

    logic [PACK_W-1:0] pack_bits;

    // if/id lands in word 0, the top two bits of the last word are padding
    assign pack_bits = {{(PACK_W-SNAP_W){1'b0}}, i_snapshot};

    always_comb begin
        o_word = '0;
        if (i_idx < 4'(`DBG_LATCH_WORDS)) begin
            o_word = pack_bits[i_idx*`DBG_WORD_W +: `DBG_WORD_W];
        end
    end

endmodule

// File: logic/dbg_mode_regs.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_mode_regs (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  dbg_pkg::mode_evt_t      i_evt,
    output logic                    o_prog_ready,
    output logic                    o_step_mode,
    output logic [`DBG_IMEM_AW-1:0] o_load_addr,
    output logic                    o_drain_done
);

    localparam int DRAIN_W = $clog2(`DBG_DRAIN_CYCLES + 1);
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`DBG_DRAIN_CYCLES);

    logic [DRAIN_W-1:0] drain_cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_prog_ready <= 1'b0;
            o_step_mode  <= 1'b0;
            o_load_addr  <= '0;
            drain_cnt    <= '0;
        end else begin
            if (i_evt.load_start) o_prog_ready <= 1'b0; // old program no longer valid
            else if (i_evt.load_done) o_prog_ready <= 1'b1;

            if (i_evt.step_start) o_step_mode <= 1'b1;
            else if (i_evt.run_start || i_evt.session_end) o_step_mode <= 1'b0;

            if (i_evt.load_start || i_evt.load_done) o_load_addr <= '0;
            else if (i_evt.load_word) o_load_addr <= o_load_addr + 3'd4; // next word

            // first tick starts the count, it then runs to the end on its own
            if (i_evt.run_start || i_evt.session_end) begin
                drain_cnt <= '0;
            end else if (drain_cnt != DRAIN_LAST && (drain_cnt != '0 || i_evt.drain_tick)) begin
                drain_cnt <= drain_cnt + 1'b1;
            end
        end
    end

    assign o_drain_done = (drain_cnt == DRAIN_LAST);

endmodule

// File: logic/dbg_pkg.sv
package dbg_pkg;

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD_WAIT,
        ST_LOAD_WRITE,
        ST_RUN,
        ST_STEP_WAIT,
        ST_STEP_EXEC,
        ST_REG_ADDR,
        ST_REG_PUSH,
        ST_LATCH_PUSH,
        ST_MEM_ADDR,
        ST_MEM_CHECK,
        ST_MEM_PUSH_ADDR,
        ST_END_PUSH,
        ST_RELEASE
    } dbg_state_e;

    // decoded host words
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_LOAD,
        CMD_CONT,
        CMD_STEP,
        CMD_NEXT,
        CMD_CANCEL
    } dbg_cmd_e;

    // field layout is owned by the pipeline, kept opaque here
    typedef struct packed { logic [63:0]  payload; } if_id_t;
    typedef struct packed { logic [138:0] payload; } id_ex_t;
    typedef struct packed { logic [75:0]  payload; } ex_mem_t;
    typedef struct packed { logic [70:0]  payload; } mem_wb_t;

    // if_id sits at the lsb end
    typedef struct packed {
        mem_wb_t mem_wb;
        ex_mem_t ex_mem;
        id_ex_t  id_ex;
        if_id_t  if_id;
    } pipe_snapshot_t;

    typedef struct packed {
        logic load_start;
        logic load_word;
        logic load_done;
        logic run_start;
        logic step_start;
        logic drain_tick;
        logic session_end;
    } mode_evt_t;

endpackage

// File: logic/dbg_settings.svh
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// widths fixed by the processor
`define DBG_WORD_W        32
`define DBG_IMEM_AW       9   // byte addressed, 128 words
`define DBG_DMEM_AW       8   // byte addressed, 64 words

// dump layout
`define DBG_REG_COUNT     32
`define DBG_LATCH_WORDS   11
`define DBG_DRAIN_CYCLES  3   // cycles after the end instruction reaches decode

// host command words, ascii packed msb first
`define DBG_CMD_LOAD      32'h006C_6F6D   // "\0lom"
`define DBG_CMD_CONT      32'h0063_6F6D   // "\0com"
`define DBG_CMD_STEP      32'h0073_746D   // "\0stm"
`define DBG_CMD_NEXT      32'h6E78_7374   // "nxst"
`define DBG_CMD_CANCEL    32'h636C_7374   // "clst"
`define DBG_END_INSTR     32'hFFFF_FFFF
`define DBG_END_MARK      32'h656E_6464   // "endd"

`endif

// File: logic/dbg_tx_fifo.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_tx_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_push,
    input  logic [`DBG_WORD_W-1:0] i_wdata,
    input  logic                   i_pop,
    output logic [`DBG_WORD_W-1:0] o_rdata,
    output logic                   o_full,
    output logic                   o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    logic [`DBG_WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = i_push && !o_full;   // overflow dropped
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr] <= i_wdata;
    end

    assign o_rdata = mem[rd_ptr];   // head word, shown before the pop
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);

endmodule

// File: logic/debug_subsystem.sv
`timescale 1ns/1ps
`include "dbg_settings.svh"

module debug_subsystem #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    // host side
    input  logic                    i_data_ready,
    input  logic [`DBG_WORD_W-1:0]  i_data,
    // pipeline side
    input  logic                    i_program_end,
    input  dbg_pkg::pipe_snapshot_t i_snapshot,
    input  logic [`DBG_WORD_W-1:0]  i_reg_data,
    input  logic [`DBG_WORD_W-1:0]  i_mem_data,
    input  logic [`DBG_IMEM_AW-1:0] i_inst_addr,
    output logic                    o_halt,
    output logic                    o_pipe_reset,
    output logic                    o_stall,
    output logic [4:0]              o_reg_addr,
    output logic [`DBG_DMEM_AW-1:0] o_mem_addr,
    output logic [`DBG_WORD_W-1:0]  o_inst,
    // transmitter side
    input  logic                    i_tx_pop,
    output logic [`DBG_WORD_W-1:0]  o_tx_data,
    output logic                    o_tx_empty
);

    dbg_pkg::mode_evt_t      evt;
    logic                    prog_ready;
    logic                    step_mode;
    logic [`DBG_IMEM_AW-1:0] load_addr;
    logic                    drain_done;
    logic                    imem_we;
    logic [`DBG_IMEM_AW-1:0] imem_addr;
    logic [`DBG_WORD_W-1:0]  imem_wdata;
    logic [3:0]              latch_idx;
    logic [`DBG_WORD_W-1:0]  latch_word;
    logic                    fifo_push;
    logic [`DBG_WORD_W-1:0]  fifo_wdata;
    logic                    fifo_full;

    dbg_mode_regs u_mode_regs (
        .i_clk(i_clk), .i_reset(i_reset), .i_evt(evt),
        .o_prog_ready(prog_ready), .o_step_mode(step_mode),
        .o_load_addr(load_addr), .o_drain_done(drain_done)
    );

    dbg_controller u_controller (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_data_ready(i_data_ready), .i_data(i_data), .i_program_end(i_program_end),
        .i_reg_data(i_reg_data), .i_mem_data(i_mem_data), .i_latch_word(latch_word),
        .i_fifo_full(fifo_full), .i_prog_ready(prog_ready), .i_step_mode(step_mode),
        .i_load_addr(load_addr), .i_drain_done(drain_done),
        .o_evt(evt), .o_halt(o_halt), .o_pipe_reset(o_pipe_reset), .o_stall(o_stall),
        .o_imem_we(imem_we), .o_imem_addr(imem_addr), .o_imem_wdata(imem_wdata),
        .o_reg_addr(o_reg_addr), .o_mem_addr(o_mem_addr), .o_latch_idx(latch_idx),
        .o_fifo_push(fifo_push), .o_fifo_wdata(fifo_wdata)
    );

    dbg_latch_pack u_latch_pack (
        .i_snapshot(i_snapshot), .i_idx(latch_idx), .o_word(latch_word)
    );

    dbg_inst_mem u_inst_mem (
        .i_clk(i_clk), .i_we(imem_we), .i_waddr(imem_addr), .i_wdata(imem_wdata),
        .i_raddr(i_inst_addr), .o_rdata(o_inst)
    );

    dbg_tx_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .i_clk(i_clk), .i_reset(i_reset), .i_push(fifo_push), .i_wdata(fifo_wdata),
        .i_pop(i_tx_pop), .o_rdata(o_tx_data), .o_full(fifo_full), .o_empty(o_tx_empty)
    );

endmodule

// File: vlog.f
+incdir+logic
logic/dbg_pkg.sv
logic/dbg_mode_regs.sv
logic/dbg_controller.sv
logic/dbg_latch_pack.sv
logic/dbg_inst_mem.sv
logic/dbg_tx_fifo.sv
logic/debug_subsystem.sv
dv/dbg_clock_gen.sv
dv/debug_subsystem_sva.sv
dv/debug_subsystem_tb.sv
